// ==== timingPkg.sv ====
package timingPkg;

	//////////////////////////////
	// Counter widths
	//////////////////////////////

	// Pixel counter width, room for 512 pixels per line
	localparam int hCountWidth = 9;

	// Line counter width, room for 512 lines per frame
	localparam int vCountWidth = 9;

	//////////////////////////////
	// Horizontal regions
	//////////////////////////////

	// Where the beam is along the line
	// Active video first, then front porch, sync pulse, back porch
	typedef enum logic [1:0] {
		hActive,
		hFrontPorch,
		hSync,
		hBackPorch
	} hPhase;

	//////////////////////////////
	// Default raster
	//////////////////////////////

	// Horizontal, in pixels at 6 MHz
	localparam int defaultHTotal = 384;
	localparam int defaultHActive = 288;
	localparam int defaultHSyncStart = 304;
	localparam int defaultHSyncWidth = 32;

	// Vertical, in lines
	localparam int defaultVTotal = 264;
	localparam int defaultVActive = 224;
	localparam int defaultVSyncStart = 240;
	localparam int defaultVSyncWidth = 8;

	// 48 MHz / 8 / 384 / 264 gives roughly 59.2 Hz frame rate

endpackage

// ==== clockDivider.sv ====
`timescale 1ns/1ns

module clockDivider (
	input logic clk48M,
	input logic rstN,
	output logic ce24,
	output logic ce12,
	output logic ce6
);

	//////////////////////////////
	// Phase counter
	//////////////////////////////

	// Eight master cycles per 6 MHz pixel
	logic [2:0] phase;

	// Free running, wraps 7 -> 0
	always_ff @(posedge clk48M or negedge rstN) begin
		if (!rstN) begin
			phase <= 3'd0;
		end else begin
			phase <= phase + 3'd1;
		end
	end

	//////////////////////////////
	// Strobe decode
	//////////////////////////////

	// Registered so every strobe is one clean master cycle wide
	// 24 MHz on odd phases, every second cycle
	// 12 MHz on phases 3 and 7
	// 6 MHz on phase 7 only, so it always lands on a 12 and 24 strobe
	always_ff @(posedge clk48M or negedge rstN) begin
		if (!rstN) begin
			ce24 <= 1'b0;
			ce12 <= 1'b0;
			ce6 <= 1'b0;
		end else begin
			ce24 <= phase[0];
			ce12 <= (phase[1:0] == 2'd3);
			ce6 <= (phase == 3'd7);
		end
	end

	// First ce6 follows reset release by eight cycles
	// Phase 7 is decoded on the eighth edge

endmodule

// ==== videoCounter.sv ====
`timescale 1ns/1ns

module videoCounter #(
	parameter int hTotal = timingPkg::defaultHTotal,
	parameter int vTotal = timingPkg::defaultVTotal
) (
	input logic clk48M,
	input logic rstN,
	input logic ce6,
	output logic [timingPkg::hCountWidth-1:0] hCount,
	output logic [timingPkg::vCountWidth-1:0] vCount,
	output logic lineEnd,
	output logic frameEnd
);

	//////////////////////////////
	// Raster limits
	//////////////////////////////

	localparam int hW = timingPkg::hCountWidth;
	localparam int vW = timingPkg::vCountWidth;

	// Last pixel and last line, sized to the counters
	localparam int hLastInt = hTotal - 1;
	localparam int vLastInt = vTotal - 1;
	localparam logic [hW-1:0] hLast = hLastInt[hW-1:0];
	localparam logic [vW-1:0] vLast = vLastInt[vW-1:0];

	// Counters sit on their final value
	logic hWrap;
	logic vWrap;

	assign hWrap = (hCount == hLast);
	assign vWrap = (vCount == vLast);

	//////////////////////////////
	// Pixel counter
	//////////////////////////////

	// One step per pixel strobe
	always_ff @(posedge clk48M or negedge rstN) begin
		if (!rstN) begin
			hCount <= '0;
		end else if (ce6) begin
			if (hWrap) begin
				hCount <= '0;
			end else begin
				hCount <= hCount + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Line counter
	//////////////////////////////

	// Steps only when the pixel counter wraps
	always_ff @(posedge clk48M or negedge rstN) begin
		if (!rstN) begin
			vCount <= '0;
		end else if (lineEnd) begin
			if (vWrap) begin
				vCount <= '0;
			end else begin
				vCount <= vCount + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Reset points
	//////////////////////////////

	// Horizontal reset point, high on the ce6 that wraps hCount
	assign lineEnd = ce6 & hWrap;

	// Vertical reset point, both counters wrap together
	assign frameEnd = lineEnd & vWrap;

	// Counters move on the edge that samples the strobe,
	// so new values show one cycle after ce6

endmodule

// ==== syncGenerator.sv ====
`timescale 1ns/1ns

module syncGenerator #(
	parameter int hActive = timingPkg::defaultHActive,
	parameter int hSyncStart = timingPkg::defaultHSyncStart,
	parameter int hSyncWidth = timingPkg::defaultHSyncWidth,
	parameter int vActive = timingPkg::defaultVActive,
	parameter int vSyncStart = timingPkg::defaultVSyncStart,
	parameter int vSyncWidth = timingPkg::defaultVSyncWidth
) (
	input logic clk48M,
	input logic rstN,
	input logic ce6,
	input logic [timingPkg::hCountWidth-1:0] hCount,
	input logic [timingPkg::vCountWidth-1:0] vCount,
	output logic nHSync,
	output logic nVSync,
	output logic nHBlank,
	output logic nVBlank,
	output logic nCompSync,
	output logic blanking
);

	//////////////////////////////
	// Region boundaries
	//////////////////////////////

	localparam int hW = timingPkg::hCountWidth;
	localparam int vW = timingPkg::vCountWidth;

	// Sync pulses end one past their last count
	localparam int hSyncEndInt = hSyncStart + hSyncWidth;
	localparam int vSyncEndInt = vSyncStart + vSyncWidth;

	// Horizontal edges, sized to hCount
	localparam logic [hW-1:0] hActiveEnd = hActive[hW-1:0];
	localparam logic [hW-1:0] hSyncBegin = hSyncStart[hW-1:0];
	localparam logic [hW-1:0] hSyncEnd = hSyncEndInt[hW-1:0];

	// Vertical edges, sized to vCount
	localparam logic [vW-1:0] vActiveEnd = vActive[vW-1:0];
	localparam logic [vW-1:0] vSyncBegin = vSyncStart[vW-1:0];
	localparam logic [vW-1:0] vSyncEnd = vSyncEndInt[vW-1:0];

	//////////////////////////////
	// Horizontal classifier
	//////////////////////////////

	// Region of the current pixel
	timingPkg::hPhase phase;

	// Regions follow in line order, so a chain of compares is enough
	// Enum values are scoped, the bare hActive here is the parameter
	always_comb begin
		if (hCount < hActiveEnd) begin
			phase = timingPkg::hActive;
		end else if (hCount < hSyncBegin) begin
			phase = timingPkg::hFrontPorch;
		end else if (hCount < hSyncEnd) begin
			phase = timingPkg::hSync;
		end else begin
			phase = timingPkg::hBackPorch;
		end
	end

	// Active-high conditions for the current position
	logic hBlankNow;
	logic hSyncNow;
	logic vBlankNow;
	logic vSyncNow;

	// Everything past active video blanks
	assign hBlankNow = (phase != timingPkg::hActive);
	assign hSyncNow = (phase == timingPkg::hSync);

	//////////////////////////////
	// Vertical decode
	//////////////////////////////

	// Lines below the visible area blank
	assign vBlankNow = (vCount >= vActiveEnd);

	// Sync window inside vertical blank
	assign vSyncNow = (vCount >= vSyncBegin) && (vCount < vSyncEnd);

	//////////////////////////////
	// Output registers
	//////////////////////////////

	// Sampled every master cycle, one cycle behind the counters
	// Composite sync is the AND of the two active-low syncs
	always_ff @(posedge clk48M or negedge rstN) begin
		if (!rstN) begin
			nHBlank <= 1'b1;
			nVBlank <= 1'b1;
			nHSync <= 1'b1;
			nVSync <= 1'b1;
			nCompSync <= 1'b1;
		end else begin
			nHBlank <= ~hBlankNow;
			nVBlank <= ~vBlankNow;
			nHSync <= ~hSyncNow;
			nVSync <= ~vSyncNow;
			nCompSync <= ~(hSyncNow | vSyncNow);
		end
	end

	//////////////////////////////
	// Latched blanking
	//////////////////////////////

	// Pixel-clocked flip-flop on the blanking lines
	// Takes the state of nHBlank and nVBlank at each ce6,
	// so it runs one pixel behind them
	always_ff @(posedge clk48M or negedge rstN) begin
		if (!rstN) begin
			blanking <= 1'b0;
		end else if (ce6) begin
			blanking <= ~(nHBlank & nVBlank);
		end
	end

endmodule

// ==== timingSubsystem.sv ====
`timescale 1ns/1ns

module timingSubsystem #(
	parameter int hTotal = timingPkg::defaultHTotal,
	parameter int hActive = timingPkg::defaultHActive,
	parameter int hSyncStart = timingPkg::defaultHSyncStart,
	parameter int hSyncWidth = timingPkg::defaultHSyncWidth,
	parameter int vTotal = timingPkg::defaultVTotal,
	parameter int vActive = timingPkg::defaultVActive,
	parameter int vSyncStart = timingPkg::defaultVSyncStart,
	parameter int vSyncWidth = timingPkg::defaultVSyncWidth
) (
	input logic clk48M,
	input logic rstN,
	// Clock enables
	output logic ce24,
	output logic ce12,
	output logic ce6,
	// Raster position and reset points
	output logic [timingPkg::hCountWidth-1:0] hCount,
	output logic [timingPkg::vCountWidth-1:0] vCount,
	output logic lineEnd,
	output logic frameEnd,
	// Video sync
	output logic nHSync,
	output logic nVSync,
	output logic nHBlank,
	output logic nVBlank,
	output logic nCompSync,
	output logic blanking
);

	//////////////////////////////
	// Clock divider
	//////////////////////////////

	// Master clock down to the 24, 12 and 6 MHz strobes
	clockDivider uClockDivider (
		.clk48M(clk48M),
		.rstN(rstN),
		.ce24(ce24),
		.ce12(ce12),
		.ce6(ce6)
	);

	//////////////////////////////
	// Raster counters
	//////////////////////////////

	// Only the totals matter here
	videoCounter #(
		.hTotal(hTotal),
		.vTotal(vTotal)
	) uVideoCounter (
		.clk48M(clk48M),
		.rstN(rstN),
		.ce6(ce6),
		.hCount(hCount),
		.vCount(vCount),
		.lineEnd(lineEnd),
		.frameEnd(frameEnd)
	);

	//////////////////////////////
	// Sync decode
	//////////////////////////////

	// Active and sync windows go to the decoder
	syncGenerator #(
		.hActive(hActive),
		.hSyncStart(hSyncStart),
		.hSyncWidth(hSyncWidth),
		.vActive(vActive),
		.vSyncStart(vSyncStart),
		.vSyncWidth(vSyncWidth)
	) uSyncGenerator (
		.clk48M(clk48M),
		.rstN(rstN),
		.ce6(ce6),
		.hCount(hCount),
		.vCount(vCount),
		.nHSync(nHSync),
		.nVSync(nVSync),
		.nHBlank(nHBlank),
		.nVBlank(nVBlank),
		.nCompSync(nCompSync),
		.blanking(blanking)
	);

endmodule

// ==== timingSubsystem_checker.sv ====
`timescale 1ns/1ns

module timingSubsystem_checker (
	input logic clk48M,
	input logic rstN,
	input logic ce24,
	input logic ce12,
	input logic ce6,
	input logic lineEnd,
	input logic frameEnd,
	input logic nHSync,
	input logic nVSync,
	input logic nCompSync
);

	// Running total of failed properties
	int failCount = 0;

	//////////////////////////////
	// Strobe properties
	//////////////////////////////

	// Pixel strobe is one cycle wide
	assert property (@(posedge clk48M) disable iff (!rstN) ce6 |=> !ce6)
	else begin
		$error("ce6 high on two consecutive cycles");
		failCount++;
	end

	// 6 MHz strobe sits on a 12 and a 24 MHz strobe
	assert property (@(posedge clk48M) disable iff (!rstN) ce6 |-> (ce12 && ce24))
	else begin
		$error("ce6 without ce12 and ce24");
		failCount++;
	end

	//////////////////////////////
	// Raster and sync properties
	//////////////////////////////

	// Frame end is always a line end too
	assert property (@(posedge clk48M) disable iff (!rstN) frameEnd |-> lineEnd)
	else begin
		$error("frameEnd without lineEnd");
		failCount++;
	end

	// Composite sync low exactly when a sync is low
	assert property (@(posedge clk48M) disable iff (!rstN) nCompSync == (nHSync & nVSync))
	else begin
		$error("nCompSync does not follow nHSync and nVSync");
		failCount++;
	end

endmodule

bind timingSubsystem timingSubsystem_checker i_checker (
	.clk48M(clk48M),
	.rstN(rstN),
	.ce24(ce24),
	.ce12(ce12),
	.ce6(ce6),
	.lineEnd(lineEnd),
	.frameEnd(frameEnd),
	.nHSync(nHSync),
	.nVSync(nVSync),
	.nCompSync(nCompSync)
);

// ==== timingSubsystemTb.sv ====
`timescale 1ns/1ns

module timingSubsystemTb;

	//////////////////////////////
	// Raster under test
	//////////////////////////////

	// Small 48 by 20 raster keeps runs short
	localparam int tbHTotal = 48;
	localparam int tbHActive = 36;
	localparam int tbHSyncStart = 38;
	localparam int tbHSyncWidth = 4;
	localparam int tbVTotal = 20;
	localparam int tbVActive = 16;
	localparam int tbVSyncStart = 17;
	localparam int tbVSyncWidth = 2;

	// Master cycles per pixel, line and frame
	localparam int pixelCycles = 8;
	localparam int lineCycles = tbHTotal * pixelCycles;
	localparam int frameCycles = lineCycles * tbVTotal;

	// Three frames plus margin
	localparam int timeoutLimit = 25000;

	logic clk48M;
	logic rstN;
	logic ce24;
	logic ce12;
	logic ce6;
	logic [timingPkg::hCountWidth-1:0] hCount;
	logic [timingPkg::vCountWidth-1:0] vCount;
	logic lineEnd;
	logic frameEnd;
	logic nHSync;
	logic nVSync;
	logic nHBlank;
	logic nVBlank;
	logic nCompSync;
	logic blanking;

	// Reference model state
	// Cycles since reset release, pixel strobes so far, strobes one cycle back
	int cycleCount = 0;
	int pulseCount = 0;
	int prevPulseCount = 0;
	int errorCount = 0;
	int timeoutCount = 0;
	integer seed;

	timingSubsystem #(
		.hTotal(tbHTotal),
		.hActive(tbHActive),
		.hSyncStart(tbHSyncStart),
		.hSyncWidth(tbHSyncWidth),
		.vTotal(tbVTotal),
		.vActive(tbVActive),
		.vSyncStart(tbVSyncStart),
		.vSyncWidth(tbVSyncWidth)
	) i_dut (
		.clk48M(clk48M),
		.rstN(rstN),
		.ce24(ce24),
		.ce12(ce12),
		.ce6(ce6),
		.hCount(hCount),
		.vCount(vCount),
		.lineEnd(lineEnd),
		.frameEnd(frameEnd),
		.nHSync(nHSync),
		.nVSync(nVSync),
		.nHBlank(nHBlank),
		.nVBlank(nVBlank),
		.nCompSync(nCompSync),
		.blanking(blanking)
	);

	// 100 ns master clock
	initial begin
		clk48M = 1'b0;
		forever #50 clk48M = ~clk48M;
	end

	// Run limit
	always @(posedge clk48M) begin
		timeoutCount++;
		if (timeoutCount >= timeoutLimit) begin
			$display("Simulation timed out after %0d cycles", timeoutCount);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Raster position after a number of pixel strobes
	function automatic int pixelOf(input int pulses);
		return pulses % tbHTotal;
	endfunction

	function automatic int lineOf(input int pulses);
		return (pulses / tbHTotal) % tbVTotal;
	endfunction

	// Horizontal region of a pixel
	function automatic timingPkg::hPhase regionOf(input int h);
		timingPkg::hPhase region;
		region = timingPkg::hBackPorch;
		if (h < tbHSyncStart + tbHSyncWidth) region = timingPkg::hSync;
		if (h < tbHSyncStart) region = timingPkg::hFrontPorch;
		if (h < tbHActive) region = timingPkg::hActive;
		return region;
	endfunction

	function automatic bit inVSync(input int v);
		return (v >= tbVSyncStart) && (v < tbVSyncStart + tbVSyncWidth);
	endfunction

	// Either blanking condition at a raster position
	function automatic bit blankAt(input int pulses);
		return (regionOf(pixelOf(pulses)) != timingPkg::hActive)
			|| (lineOf(pulses) >= tbVActive);
	endfunction

	//////////////////////////////
	// Checking helpers
	//////////////////////////////

	task automatic checkValue(input string what, input int actual, input int expected);
		assert (actual == expected) else begin
			$display("MISMATCH at %0t ns: %s is %0d, expected %0d",
				$time, what, actual, expected);
			errorCount++;
		end
	endtask

	// One falling edge, then every output against the model
	task automatic sampleCycle();
		bit expCe6;
		bit expLineEnd;
		int h;
		int v;
		int sv;
		timingPkg::hPhase region;
		@(negedge clk48M);
		if (!rstN) begin
			cycleCount = 0;
			pulseCount = 0;
			prevPulseCount = 0;
		end else begin
			cycleCount++;
		end
		expCe6 = (cycleCount > 0) && (cycleCount % pixelCycles == 0);
		h = pixelOf(pulseCount);
		v = lineOf(pulseCount);
		expLineEnd = expCe6 && (h == tbHTotal - 1);
		checkValue("ce24", int'(ce24), int'((cycleCount > 0) && (cycleCount % 2 == 0)));
		checkValue("ce12", int'(ce12), int'((cycleCount > 0) && (cycleCount % 4 == 0)));
		checkValue("ce6", int'(ce6), int'(expCe6));
		checkValue("hCount", int'(hCount), h);
		checkValue("vCount", int'(vCount), v);
		checkValue("lineEnd", int'(lineEnd), int'(expLineEnd));
		checkValue("frameEnd", int'(frameEnd), int'(expLineEnd && (v == tbVTotal - 1)));
		// Sync outputs one cycle behind the counters
		region = regionOf(pixelOf(prevPulseCount));
		sv = lineOf(prevPulseCount);
		checkValue("nHBlank", int'(nHBlank), int'(region == timingPkg::hActive));
		checkValue("nHSync", int'(nHSync), int'(region != timingPkg::hSync));
		checkValue("nVBlank", int'(nVBlank), int'(sv < tbVActive));
		checkValue("nVSync", int'(nVSync), int'(!inVSync(sv)));
		checkValue("nCompSync", int'(nCompSync),
			int'((region != timingPkg::hSync) && !inVSync(sv)));
		// Latched blanking holds the pixel before
		checkValue("blanking", int'(blanking),
			(pulseCount == 0) ? 0 : int'(blankAt(pulseCount - 1)));
		prevPulseCount = pulseCount;
		if (expCe6) pulseCount++;
	endtask

	task automatic checkResetState();
		checkValue("ce24 in reset state", int'(ce24), 0);
		checkValue("ce12 in reset state", int'(ce12), 0);
		checkValue("ce6 in reset state", int'(ce6), 0);
		checkValue("hCount in reset state", int'(hCount), 0);
		checkValue("vCount in reset state", int'(vCount), 0);
		checkValue("nHSync in reset state", int'(nHSync), 1);
		checkValue("nVSync in reset state", int'(nVSync), 1);
		checkValue("nHBlank in reset state", int'(nHBlank), 1);
		checkValue("nVBlank in reset state", int'(nVBlank), 1);
		checkValue("nCompSync in reset state", int'(nCompSync), 1);
		checkValue("blanking in reset state", int'(blanking), 0);
	endtask

	// Two cycles low, released on a falling edge
	task automatic applyReset();
		rstN = 1'b0;
		repeat (2) begin
			sampleCycle();
			checkResetState();
		end
		rstN = 1'b1;
		checkResetState();
	endtask

	task automatic waitForCe6();
		int waited;
		waited = 0;
		do begin
			sampleCycle();
			waited++;
		end while (!ce6 && waited < 2 * pixelCycles);
		assert (ce6) else begin
			$display("Failure at %0t ns: no ce6 for %0d cycles", $time, waited);
			errorCount++;
		end
	endtask

	task automatic waitForLineEnd();
		int waited;
		waited = 0;
		do begin
			sampleCycle();
			waited++;
		end while (!lineEnd && waited < lineCycles + pixelCycles);
		assert (lineEnd) else begin
			$display("Failure at %0t ns: no lineEnd for %0d cycles", $time, waited);
			errorCount++;
		end
	endtask

	// Called at reset release
	task automatic checkFirstPixel();
		int waited;
		waited = 0;
		do begin
			sampleCycle();
			waited++;
		end while (!ce6 && waited < 2 * pixelCycles);
		assert (ce6) else begin
			$display("Failure at %0t ns: no ce6 after reset release", $time);
			errorCount++;
		end
		checkValue("cycles from reset release to first ce6", waited, pixelCycles);
		checkValue("hCount at first ce6", int'(hCount), 0);
		checkValue("vCount at first ce6", int'(vCount), 0);
		sampleCycle();
		checkValue("hCount after first ce6", int'(hCount), 1);
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic resetTest();
		applyReset();
		checkFirstPixel();
	endtask

	task automatic strobeRatioTest();
		int n24;
		int n12;
		int n6;
		n24 = 0;
		n12 = 0;
		n6 = 0;
		repeat (64) begin
			sampleCycle();
			if (ce24) n24++;
			if (ce12) n12++;
			if (ce6) begin
				n6++;
				checkValue("ce12 on a ce6 cycle", int'(ce12), 1);
				checkValue("ce24 on a ce6 cycle", int'(ce24), 1);
			end
		end
		checkValue("ce24 pulses in 64 cycles", n24, 32);
		checkValue("ce12 pulses in 64 cycles", n12, 16);
		checkValue("ce6 pulses in 64 cycles", n6, 8);
	endtask

	// Sync decode checked two cycles after each ce6, on the new pixel
	task automatic horizontalTest();
		int px;
		int nextPx;
		waitForLineEnd();
		for (px = 0; px < tbHTotal; px++) begin
			waitForCe6();
			checkValue("hCount on ce6", int'(hCount), px);
			checkValue("lineEnd on ce6", int'(lineEnd), (px == tbHTotal - 1) ? 1 : 0);
			repeat (2) sampleCycle();
			nextPx = (px + 1) % tbHTotal;
			checkValue("hCount after ce6", int'(hCount), nextPx);
			checkValue("nHBlank after ce6", int'(nHBlank), (nextPx >= tbHActive) ? 0 : 1);
			checkValue("nHSync after ce6", int'(nHSync),
				(nextPx >= tbHSyncStart && nextPx < tbHSyncStart + tbHSyncWidth) ? 0 : 1);
		end
	endtask

	task automatic verticalTest();
		int line;
		int oldV;
		int newV;
		int frames;
		frames = 0;
		for (line = 0; line < tbVTotal; line++) begin
			waitForLineEnd();
			// Line the model holds on this strobe
			oldV = lineOf(pulseCount - 1);
			checkValue("vCount on lineEnd", int'(vCount), oldV);
			if (frameEnd) begin
				frames++;
				checkValue("vCount on frameEnd", int'(vCount), tbVTotal - 1);
				checkValue("hCount on frameEnd", int'(hCount), tbHTotal - 1);
			end
			sampleCycle();
			newV = (oldV + 1) % tbVTotal;
			checkValue("vCount after lineEnd", int'(vCount), newV);
			checkValue("hCount after lineEnd", int'(hCount), 0);
			sampleCycle();
			checkValue("nVBlank after lineEnd", int'(nVBlank), (newV >= tbVActive) ? 0 : 1);
			checkValue("nVSync after lineEnd", int'(nVSync),
				(newV >= tbVSyncStart && newV < tbVSyncStart + tbVSyncWidth) ? 0 : 1);
		end
		checkValue("frameEnd pulses in one frame", frames, 1);
	endtask

	task automatic syncAndBlankTest();
		int px;
		int shown;
		bit havePrev;
		bit prevCond;
		havePrev = 1'b0;
		prevCond = 1'b0;
		for (px = 0; px < tbHTotal * tbVTotal; px++) begin
			waitForCe6();
			// Model already counted this strobe
			shown = pulseCount - 1;
			// Syncs on this ce6 still show the pixel held before it
			checkValue("nCompSync on ce6", int'(nCompSync),
				int'((regionOf(pixelOf(shown)) != timingPkg::hSync)
					&& !inVSync(lineOf(shown))));
			if (havePrev) begin
				checkValue("blanking against previous ce6", int'(blanking), int'(prevCond));
			end
			prevCond = blankAt(shown);
			havePrev = 1'b1;
		end
	endtask

	task automatic midFrameResetTest();
		int delay;
		delay = lineCycles + (($random(seed) & 32'h7fffffff) % (frameCycles / 2));
		repeat (delay) sampleCycle();
		applyReset();
		checkFirstPixel();
		waitForLineEnd();
		checkValue("vCount on first lineEnd after reset", int'(vCount), 0);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int checkerFails;
		rstN = 1'b0;
		seed = 32'h71cea02e;
		resetTest();
		strobeRatioTest();
		horizontalTest();
		verticalTest();
		syncAndBlankTest();
		midFrameResetTest();
		checkerFails = i_dut.i_checker.failCount;
		$display("Error count: %0d testbench checks, %0d checker assertions",
			errorCount, checkerFails);
		if (errorCount == 0 && checkerFails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== files.f ====
timingPkg.sv
clockDivider.sv
videoCounter.sv
syncGenerator.sv
timingSubsystem.sv
timingSubsystem_checker.sv
timingSubsystemTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the timing subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module timingSubsystemTb \
	-o simTiming

# Keep running past assertion errors so the testbench reaches its report
status=0
./obj_dir/simTiming +verilator+error+limit+100 > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "ERRORS FOUND" "$LOG" || [ "$status" -ne 0 ]; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
